//--- common/rv32iPkg.sv
// shared definitions for the rv32i pipeline core
// opcodes, ALU and forwarding encodings, and the payload of each stage register

package rv32iPkg;

	localparam int xlen = 32;

	// base opcodes of the supported subset
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;

	localparam logic [xlen-1:0] nopInstr = 32'h0000_0013; // addi x0,x0,0

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOpT;

	// execute operand source
	typedef enum logic [1:0] {fromReg, fromMem, fromWb} fwdSelT;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] pcPlus4;
		logic [xlen-1:0] instr;
	} ifIdT;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] pcPlus4;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] imm;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		aluOpT           aluOp;
		logic            aluSrcImm; // b operand from imm
		logic            aSrcPc;    // a operand from pc, auipc
		logic            regWrite;
		logic            memToReg;
		logic            memWrite;
		logic            linkPc;    // jal/jalr write pc+4
	} idExT;

	typedef struct packed {
		logic [xlen-1:0] aluOut;
		logic [xlen-1:0] storeData;
		logic [4:0]      rd;
		logic            regWrite;
		logic            memToReg;
		logic            memWrite;
	} exMemT;

	typedef struct packed {
		logic [xlen-1:0] result;
		logic [xlen-1:0] loadData;
		logic [4:0]      rd;
		logic            regWrite;
		logic            memToReg;
	} memWbT;

	// bubbles loaded on reset or clear
	localparam ifIdT  ifIdBubble  = '{pc: '0, pcPlus4: '0, instr: nopInstr};
	localparam idExT  idExBubble  = '0;
	localparam exMemT exMemBubble = '0;
	localparam memWbT memWbBubble = '0;

endpackage

//--- hw/core/pipeReg.sv
// stage register between two pipeline stages
// payload type and bubble value are set per stage boundary

`timescale 1ns/1ps

module pipeReg #(
	parameter type     payloadT = logic [31:0],
	parameter payloadT bubble   = '0
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    en,
	input  logic    clear,
	input  payloadT d,
	output payloadT q
);

	always_ff @(posedge clk) begin
		if (reset || clear)
			q <= bubble; // clear beats hold
		else if (en)
			q <= d;
	end

	// the hazard unit only squashes a stage that is also allowed to advance
	assert property (@(posedge clk) disable iff (reset) clear |-> en)
		else $error("clear requested on a frozen stage register");

endmodule

//--- hw/core/regFile.sv
// 32 x 32 integer register file, two read ports and one write port
// reads see a same-cycle write so writeback needs no extra forwarding path

`timescale 1ns/1ps

module regFile
	import rv32iPkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic            we,
	input  logic [4:0]      wa,
	input  logic [xlen-1:0] wd,
	output logic [xlen-1:0] rdata1,
	output logic [xlen-1:0] rdata2
);

	logic [xlen-1:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd; // x0 never written
		end
	end

	// write-before-read bypass
	assign rdata1 = (rs1 == 5'd0) ? '0 : (we && wa == rs1) ? wd : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : (we && wa == rs2) ? wd : regs[rs2];

	// x0 storage stays zero whatever writeback aims at it
	assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
		else $error("x0 holds a non-zero value");

endmodule

//--- hw/core/instrDecode.sv
// decode stage: controls, immediates, branch compare and next-pc target
// branches and jumps resolve here so only one fetched slot is squashed

`timescale 1ns/1ps

module instrDecode
	import rv32iPkg::*;
(
	input  logic [xlen-1:0] instr,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] pcPlus4,
	input  logic [xlen-1:0] rdata1,
	input  logic [xlen-1:0] rdata2,
	input  logic [xlen-1:0] aluOutM,
	input  logic            fwdA,
	input  logic            fwdB,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output logic [4:0]      rd,
	output idExT            idEx,
	output logic            branchOrJump,
	output logic            usesRs1,
	output logic            usesRs2,
	output logic            redirect,
	output logic [xlen-1:0] targetPc
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [xlen-1:0] immI, immS, immB, immU, immJ, imm;
	logic [xlen-1:0] opA, opB;
	logic            isBranch, isJal, isJalr, taken;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? aluSub : aluAdd;
			3'b001:  return aluSll;
			3'b010:  return aluSlt;
			3'b011:  return aluSltu;
			3'b100:  return aluXor;
			3'b101:  return alt ? aluSra : aluSrl;
			3'b110:  return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	always_comb begin
		idEx = '{pc: pc, pcPlus4: pcPlus4, a: rdata1, b: rdata2, imm: immI,
			rs1: rs1, rs2: rs2, rd: rd, aluOp: aluAdd, default: 1'b0};
		usesRs1  = 1'b0;
		usesRs2  = 1'b0;
		isBranch = 1'b0;
		isJal    = 1'b0;
		isJalr   = 1'b0;
		case (opcode)
			opLui: begin
				idEx.imm = immU;
				idEx.aluOp = aluPassB;
				idEx.aluSrcImm = 1'b1;
				idEx.regWrite = 1'b1;
			end
			opAuipc: begin
				idEx.imm = immU;
				idEx.aSrcPc = 1'b1;
				idEx.aluSrcImm = 1'b1;
				idEx.regWrite = 1'b1;
			end
			opJal: begin
				idEx.imm = immJ;
				idEx.linkPc = 1'b1;
				idEx.regWrite = 1'b1;
				isJal = 1'b1;
			end
			opJalr: begin
				idEx.linkPc = 1'b1;
				idEx.regWrite = 1'b1;
				usesRs1 = 1'b1;
				isJalr = 1'b1;
			end
			opBranch: begin
				idEx.imm = immB;
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
				isBranch = 1'b1;
			end
			opLoad: begin
				idEx.aluSrcImm = 1'b1;
				idEx.regWrite = 1'b1;
				idEx.memToReg = 1'b1;
				usesRs1 = 1'b1;
			end
			opStore: begin
				idEx.imm = immS;
				idEx.aluSrcImm = 1'b1;
				idEx.memWrite = 1'b1;
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			opImm: begin
				idEx.aluOp = aluFromFunct(funct3, funct3 == 3'b101 && instr[30]); // srai only
				idEx.aluSrcImm = 1'b1;
				idEx.regWrite = 1'b1;
				usesRs1 = 1'b1;
			end
			opReg: begin
				idEx.aluOp = aluFromFunct(funct3, instr[30]);
				idEx.regWrite = 1'b1;
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			default: ; // unsupported opcodes decode as a bubble
		endcase
	end

	assign imm = idEx.imm;

	// compare operands, memory stage result forwarded in
	assign opA = fwdA ? aluOutM : rdata1;
	assign opB = fwdB ? aluOutM : rdata2;

	always_comb begin
		case (funct3)
			3'b000:  taken = (opA == opB);
			3'b001:  taken = (opA != opB);
			3'b100:  taken = ($signed(opA) < $signed(opB));
			3'b101:  taken = ($signed(opA) >= $signed(opB));
			3'b110:  taken = (opA < opB);
			3'b111:  taken = (opA >= opB);
			default: taken = 1'b0;
		endcase
	end

	assign targetPc = isJalr ? ((opA + immI) & ~32'd1) : (pc + imm);
	assign redirect = isJal | isJalr | (isBranch & taken);
	assign branchOrJump = isBranch | isJal | isJalr;

endmodule

//--- hw/core/execStage.sv
// execute stage: operand forwarding and the ALU
// produces the result headed for memory and the store data

`timescale 1ns/1ps

module execStage
	import rv32iPkg::*;
(
	input  idExT            idEx,
	input  fwdSelT          fwdA,
	input  fwdSelT          fwdB,
	input  logic [xlen-1:0] aluOutM,
	input  logic [xlen-1:0] resultW,
	output logic [xlen-1:0] aluOut,
	output logic [xlen-1:0] storeData
);

	logic [xlen-1:0] srcA, srcB, aluA, aluB, aluRes;
	logic [4:0]      shamt;

	always_comb begin
		case (fwdA)
			fromMem: srcA = aluOutM;
			fromWb:  srcA = resultW;
			default: srcA = idEx.a;
		endcase
		case (fwdB)
			fromMem: srcB = aluOutM;
			fromWb:  srcB = resultW;
			default: srcB = idEx.b;
		endcase
	end

	assign aluA  = idEx.aSrcPc ? idEx.pc : srcA;
	assign aluB  = idEx.aluSrcImm ? idEx.imm : srcB;
	assign shamt = aluB[4:0];

	always_comb begin
		case (idEx.aluOp)
			aluAdd:  aluRes = aluA + aluB;
			aluSub:  aluRes = aluA - aluB;
			aluSll:  aluRes = aluA << shamt;
			aluSlt:  aluRes = {31'b0, $signed(aluA) < $signed(aluB)};
			aluSltu: aluRes = {31'b0, aluA < aluB};
			aluXor:  aluRes = aluA ^ aluB;
			aluSrl:  aluRes = aluA >> shamt;
			aluSra:  aluRes = $signed(aluA) >>> shamt;
			aluOr:   aluRes = aluA | aluB;
			aluAnd:  aluRes = aluA & aluB;
			default: aluRes = aluB; // lui
		endcase
	end

	assign aluOut    = idEx.linkPc ? idEx.pcPlus4 : aluRes; // link value for jal/jalr
	assign storeData = srcB;

endmodule

//--- hw/core/hazardUnit.sv
// forwarding selects, stalls and flushes for the whole pipeline
// iWait and dWait freeze stages here, nowhere else

`timescale 1ns/1ps

module hazardUnit
	import rv32iPkg::*;
(
	input  logic [4:0] rs1D, rs2D,
	input  logic       usesRs1, usesRs2,
	input  logic       branchOrJump, redirect,
	input  logic [4:0] rs1E, rs2E, rdE,
	input  logic       regWriteE, memToRegE,
	input  logic [4:0] rdM,
	input  logic       regWriteM, memToRegM, memWriteM,
	input  logic [4:0] rdW,
	input  logic       regWriteW,
	input  logic       iWait, dWait,
	output fwdSelT     fwdAE, fwdBE,
	output logic       fwdAD, fwdBD,
	output logic       pcEn, ifIdEn, ifIdClear,
	output logic       idExEn, idExClear,
	output logic       exMemEn, memWbEn,
	output logic       memAccessM
);

	logic hitE, hitLoadM, loadUse, branchStall, stallD;

	// decode source registers against a destination in execute or memory
	assign hitE     = regWriteE && rdE != 5'd0 &&
		((usesRs1 && rs1D == rdE) || (usesRs2 && rs2D == rdE));
	assign hitLoadM = memToRegM && regWriteM && rdM != 5'd0 &&
		((usesRs1 && rs1D == rdM) || (usesRs2 && rs2D == rdM));

	assign loadUse     = hitE && memToRegE;
	assign branchStall = branchOrJump && (hitE || hitLoadM); // 2 cycles behind a load
	assign stallD      = loadUse || branchStall;

	always_comb begin
		fwdAE = fromReg;
		fwdBE = fromReg;
		if (regWriteM && rdM != 5'd0 && rdM == rs1E)      fwdAE = fromMem;
		else if (regWriteW && rdW != 5'd0 && rdW == rs1E) fwdAE = fromWb;
		if (regWriteM && rdM != 5'd0 && rdM == rs2E)      fwdBE = fromMem;
		else if (regWriteW && rdW != 5'd0 && rdW == rs2E) fwdBE = fromWb;
	end

	// branch compare only, loads in memory are covered by the stall
	assign fwdAD = regWriteM && rdM != 5'd0 && rdM == rs1D;
	assign fwdBD = regWriteM && rdM != 5'd0 && rdM == rs2D;

	assign pcEn      = !stallD && !iWait && !dWait;
	assign ifIdEn    = pcEn;
	assign ifIdClear = pcEn && redirect; // squash the wrong-path fetch
	assign idExEn    = !dWait;
	assign idExClear = !dWait && (stallD || iWait); // bubble into execute
	assign exMemEn   = !dWait;
	assign memWbEn   = !dWait;

	assign memAccessM = memWriteM || memToRegM;

endmodule

//--- hw/core/rv32iCore.sv
// five-stage in-order rv32i core with decode-stage branch resolution
// instruction and data memories sit outside, behind iWait/dWait handshakes

`timescale 1ns/1ps

module rv32iCore
	import rv32iPkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic [xlen-1:0] imemInstn,
	input  logic [xlen-1:0] dmemRd,
	input  logic            iWait,
	input  logic            dWait,
	output logic [xlen-1:0] pcImem,
	output logic [xlen-1:0] dmemAddr,
	output logic [xlen-1:0] dmemWd,
	output logic            dmemWe,
	output logic            memAccessM
);

	logic [xlen-1:0] pcF, pcPlus4F, targetPc, resultW, aluOutE, storeDataE;
	logic [xlen-1:0] rdata1, rdata2;
	logic [4:0]      rs1D, rs2D;
	logic            usesRs1, usesRs2, branchOrJump, redirect, fwdAD, fwdBD;
	logic            pcEn, ifIdEn, ifIdClear, idExEn, idExClear, exMemEn, memWbEn;
	fwdSelT          fwdAE, fwdBE;
	ifIdT            ifIdD, ifIdQ;
	idExT            idExD, idExQ;
	exMemT           exMemD, exMemQ;
	memWbT           memWbD, memWbQ;

	// fetch
	assign pcPlus4F = pcF + 32'd4;
	assign pcImem   = pcF;

	always_ff @(posedge clk) begin
		if (reset)
			pcF <= '0;
		else if (pcEn)
			pcF <= redirect ? targetPc : pcPlus4F;
	end

	assign ifIdD = '{pc: pcF, pcPlus4: pcPlus4F, instr: imemInstn};

	pipeReg #(.payloadT(ifIdT), .bubble(ifIdBubble)) ifIdReg (
		.clk(clk), .reset(reset), .en(ifIdEn), .clear(ifIdClear),
		.d(ifIdD), .q(ifIdQ)
	);

	// decode
	instrDecode decode (
		.instr(ifIdQ.instr), .pc(ifIdQ.pc), .pcPlus4(ifIdQ.pcPlus4),
		.rdata1(rdata1), .rdata2(rdata2), .aluOutM(exMemQ.aluOut),
		.fwdA(fwdAD), .fwdB(fwdBD),
		.rs1(rs1D), .rs2(rs2D), .rd(), .idEx(idExD),
		.branchOrJump(branchOrJump), .usesRs1(usesRs1), .usesRs2(usesRs2),
		.redirect(redirect), .targetPc(targetPc)
	);

	regFile regs (
		.clk(clk), .reset(reset), .rs1(rs1D), .rs2(rs2D),
		.we(memWbQ.regWrite), .wa(memWbQ.rd), .wd(resultW),
		.rdata1(rdata1), .rdata2(rdata2)
	);

	pipeReg #(.payloadT(idExT), .bubble(idExBubble)) idExReg (
		.clk(clk), .reset(reset), .en(idExEn), .clear(idExClear),
		.d(idExD), .q(idExQ)
	);

	// execute
	execStage exec (
		.idEx(idExQ), .fwdA(fwdAE), .fwdB(fwdBE),
		.aluOutM(exMemQ.aluOut), .resultW(resultW),
		.aluOut(aluOutE), .storeData(storeDataE)
	);

	assign exMemD = '{aluOut: aluOutE, storeData: storeDataE, rd: idExQ.rd,
		regWrite: idExQ.regWrite, memToReg: idExQ.memToReg, memWrite: idExQ.memWrite};

	pipeReg #(.payloadT(exMemT), .bubble(exMemBubble)) exMemReg (
		.clk(clk), .reset(reset), .en(exMemEn), .clear(1'b0),
		.d(exMemD), .q(exMemQ)
	);

	// memory, held steady by exMemReg while dWait is high
	assign dmemAddr = exMemQ.aluOut;
	assign dmemWd   = exMemQ.storeData;
	assign dmemWe   = exMemQ.memWrite;

	assign memWbD = '{result: exMemQ.aluOut, loadData: dmemRd, rd: exMemQ.rd,
		regWrite: exMemQ.regWrite, memToReg: exMemQ.memToReg};

	pipeReg #(.payloadT(memWbT), .bubble(memWbBubble)) memWbReg (
		.clk(clk), .reset(reset), .en(memWbEn), .clear(1'b0),
		.d(memWbD), .q(memWbQ)
	);

	// writeback
	assign resultW = memWbQ.memToReg ? memWbQ.loadData : memWbQ.result;

	hazardUnit hazards (
		.rs1D(rs1D), .rs2D(rs2D), .usesRs1(usesRs1), .usesRs2(usesRs2),
		.branchOrJump(branchOrJump), .redirect(redirect),
		.rs1E(idExQ.rs1), .rs2E(idExQ.rs2), .rdE(idExQ.rd),
		.regWriteE(idExQ.regWrite), .memToRegE(idExQ.memToReg),
		.rdM(exMemQ.rd), .regWriteM(exMemQ.regWrite),
		.memToRegM(exMemQ.memToReg), .memWriteM(exMemQ.memWrite),
		.rdW(memWbQ.rd), .regWriteW(memWbQ.regWrite),
		.iWait(iWait), .dWait(dWait),
		.fwdAE(fwdAE), .fwdBE(fwdBE), .fwdAD(fwdAD), .fwdBD(fwdBD),
		.pcEn(pcEn), .ifIdEn(ifIdEn), .ifIdClear(ifIdClear),
		.idExEn(idExEn), .idExClear(idExClear),
		.exMemEn(exMemEn), .memWbEn(memWbEn), .memAccessM(memAccessM)
	);

	// the redirecting instruction moves on into execute while its wrong-path fetch is squashed
	assert property (@(posedge clk) disable iff (reset) ifIdClear |=> idExQ == $past(idExD))
		else $error("branch in decode dropped by stall and flush together");

endmodule

//--- test/tbMem.sv
// instruction and data memory model for the core testbench
// answers combinationally, counts stores and draws random waits when enabled

`timescale 1ns/1ps

module tbMem
	import rv32iPkg::*;
(
	input  logic            clk,
	input  logic            clearMem,
	input  logic            waitMode,
	input  logic [xlen-1:0] pcImem,
	input  logic [xlen-1:0] dmemAddr,
	input  logic [xlen-1:0] dmemWd,
	input  logic            dmemWe,
	output logic [xlen-1:0] imemInstn,
	output logic [xlen-1:0] dmemRd,
	output logic            iWait,
	output logic            dWait
);

	logic [xlen-1:0] imem [0:255]; // written by the testbench
	logic [xlen-1:0] dmem [0:255];
	int              storeCount [0:255];

	assign imemInstn = imem[pcImem[9:2]];
	assign dmemRd    = dmem[dmemAddr[9:2]];

	always @(posedge clk) begin
		if (clearMem) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= {~(16'(i) << 2), 16'(i) << 2}; // fill from byte address
				storeCount[i] <= 0;
			end
		end else if (dmemWe && !dWait) begin
			dmem[dmemAddr[9:2]] <= dmemWd;
			storeCount[dmemAddr[9:2]] <= storeCount[dmemAddr[9:2]] + 1;
		end
	end

	// waits change 1 ns after the edge
	initial begin
		iWait = 1'b0;
		dWait = 1'b0;
		void'($urandom(94999));
		forever begin
			@(posedge clk);
			#1;
			iWait = waitMode && ($urandom_range(3) == 0);
			dWait = waitMode && ($urandom_range(3) == 0);
		end
	end

endmodule

//--- test/tbCore.sv
// directed tests for the rv32i pipeline core
// each test loads a hand-assembled program, runs it to the end store and checks memory

`timescale 1ns/1ps

module tbCore
	import rv32iPkg::*;
();

	logic            clk, reset, clearMem, waitMode;
	logic [xlen-1:0] imemInstn, dmemRd, pcImem, dmemAddr, dmemWd;
	logic            iWait, dWait, dmemWe, memAccessM;
	logic [31:0]     prog[$];
	logic [31:0]     expAddr[$];
	logic [31:0]     expVal[$];
	int              loadCount; // completed loads since the last reset

	rv32iCore dut_i (.clk(clk), .reset(reset), .imemInstn(imemInstn), .dmemRd(dmemRd),
		.iWait(iWait), .dWait(dWait), .pcImem(pcImem), .dmemAddr(dmemAddr),
		.dmemWd(dmemWd), .dmemWe(dmemWe), .memAccessM(memAccessM));

	tbMem mem_i (.clk(clk), .clearMem(clearMem), .waitMode(waitMode), .pcImem(pcImem),
		.dmemAddr(dmemAddr), .dmemWd(dmemWd), .dmemWe(dmemWe), .imemInstn(imemInstn),
		.dmemRd(dmemRd), .iWait(iWait), .dWait(dWait));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// hand assembler
	function automatic logic [31:0] aluImm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
			logic [11:0] imm);
		return {imm, rs1, f3, rd, opImm};
	endfunction
	function automatic logic [31:0] aluReg(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction
	function automatic logic [31:0] lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, opLoad};
	endfunction
	function automatic logic [31:0] sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction
	function automatic logic [31:0] branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
			logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
	endfunction
	function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
	endfunction
	function automatic logic [31:0] jalr(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, opJalr};
	endfunction

	function automatic logic [31:0] pcNow();
		return 32'(prog.size() * 4);
	endfunction

	function automatic void expectStore(logic [31:0] addr, logic [31:0] val);
		expAddr.push_back(addr);
		expVal.push_back(val);
	endfunction

	task automatic checkEq(logic [31:0] got, logic [31:0] exp, string what);
		assert (got == exp) else begin
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "mismatch");
		end
	endtask

	// every store is a memory access, loads are counted as they complete
	always @(posedge clk) begin
		if (reset) begin
			loadCount <= 0;
		end else begin
			if (dmemWe)
				checkEq({31'd0, memAccessM}, 32'd1, "memAccessM during a store");
			if (memAccessM && !dmemWe && !dWait)
				loadCount <= loadCount + 1;
		end
	end

	// program into imem, then a reset of 8 cycles that also refills dmem
	task automatic loadAndReset();
		for (int i = 0; i < 256; i++)
			mem_i.imem[i] = (i < prog.size()) ? prog[i] : nopInstr;
		@(posedge clk);
		#1;
		reset = 1'b1;
		clearMem = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		checkEq(pcImem, 32'd0, "pc in reset");
		checkEq({31'd0, dmemWe}, 32'd0, "dmemWe in reset");
		checkEq({31'd0, memAccessM}, 32'd0, "memAccessM in reset");
		reset = 1'b0;
		clearMem = 1'b0;
	endtask

	task automatic runAndCheck(string name, int loads);
		int cycles;
		int total;
		cycles = 0;
		while (mem_i.storeCount[255] == 0) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > 3000) begin
				$display("%s: timed out waiting for the end store", name);
				$display("Simulation failed");
				$fatal(1, "timeout");
			end
		end
		total = 0;
		for (int i = 0; i < 256; i++)
			total += mem_i.storeCount[i];
		checkEq(32'(total), 32'(expAddr.size() + 1), {name, " store count"});
		checkEq(32'(loadCount), 32'(loads), {name, " load count"});
		foreach (expAddr[k]) begin
			checkEq(mem_i.dmem[expAddr[k][9:2]], expVal[k], {name, " result"});
			checkEq(32'(mem_i.storeCount[expAddr[k][9:2]]), 32'd1, {name, " stores per addr"});
		end
	endtask

	function automatic void finishProgram();
		prog.push_back(sw(5'd0, 5'd0, 12'h3fc));
		prog.push_back(jal(5'd0, 21'd0)); // park
	endfunction

	task automatic testAluChain();
		logic [31:0] v [0:16];
		prog.delete();
		expAddr.delete();
		expVal.delete();
		v[0] = 0;
		prog.push_back(aluImm(3'b000, 1, 0, 12'd5));
		v[1] = 5;
		prog.push_back(aluImm(3'b000, 2, 1, -12'sd12));
		v[2] = v[1] - 12;
		prog.push_back(aluReg(7'h00, 3'b000, 3, 2, 1));
		v[3] = v[2] + v[1];
		prog.push_back(aluReg(7'h20, 3'b000, 4, 3, 2));
		v[4] = v[3] - v[2];
		prog.push_back(aluImm(3'b001, 5, 4, 12'd3));
		v[5] = v[4] << 3;
		prog.push_back(aluReg(7'h00, 3'b100, 6, 5, 3));
		v[6] = v[5] ^ v[3];
		prog.push_back(aluImm(3'b101, 7, 6, 12'h402));
		v[7] = $signed(v[6]) >>> 2;
		prog.push_back(aluReg(7'h00, 3'b101, 8, 6, 1));
		v[8] = v[6] >> v[1][4:0];
		prog.push_back(aluReg(7'h00, 3'b010, 9, 6, 4));
		v[9] = ($signed(v[6]) < $signed(v[4])) ? 1 : 0;
		prog.push_back(aluReg(7'h00, 3'b011, 10, 6, 4));
		v[10] = (v[6] < v[4]) ? 1 : 0;
		prog.push_back({20'h12345, 5'd11, opLui});
		v[11] = 32'h1234_5000;
		prog.push_back(aluReg(7'h00, 3'b110, 12, 11, 7));
		v[12] = v[11] | v[7];
		prog.push_back(aluReg(7'h00, 3'b111, 13, 12, 6));
		v[13] = v[12] & v[6];
		v[14] = pcNow() + 32'h1000;
		prog.push_back({20'h00001, 5'd14, opAuipc});
		prog.push_back(aluImm(3'b111, 15, 13, 12'hf00));
		v[15] = v[13] & 32'hffff_ff00;
		prog.push_back(aluReg(7'h00, 3'b001, 16, 15, 1));
		v[16] = v[15] << v[1][4:0];
		for (int i = 1; i <= 16; i++) begin
			prog.push_back(sw(5'(i), 5'd0, 12'(32'h100 + 4 * i)));
			expectStore(32'h100 + 4 * i, v[i]);
		end
		finishProgram();
		loadAndReset();
		runAndCheck("alu chain", 0);
	endtask

	task automatic testLoads();
		logic [31:0] w0, w1;
		prog.delete();
		expAddr.delete();
		expVal.delete();
		prog.push_back(lw(1, 0, 12'h080));
		prog.push_back(aluImm(3'b000, 2, 1, 12'd7)); // load-use
		prog.push_back(lw(3, 0, 12'h084));
		prog.push_back(sw(3, 0, 12'h200));           // load feeds store data
		prog.push_back(aluReg(7'h00, 3'b000, 4, 2, 3));
		prog.push_back(lw(5, 0, 12'h080));
		prog.push_back(lw(6, 0, 12'h084));
		prog.push_back(aluReg(7'h20, 3'b000, 7, 6, 5));
		prog.push_back(sw(2, 0, 12'h204));
		prog.push_back(sw(4, 0, 12'h208));
		prog.push_back(sw(7, 0, 12'h20c));
		finishProgram();
		loadAndReset();
		w0 = mem_i.dmem[32];
		w1 = mem_i.dmem[33];
		expectStore(32'h200, w1);
		expectStore(32'h204, w0 + 7);
		expectStore(32'h208, w0 + 7 + w1);
		expectStore(32'h20c, w1 - w0);
		runAndCheck("loads", 4);
	endtask

	task automatic testControl();
		logic [2:0]  kinds [0:5];
		logic [31:0] a, b, q;
		logic        taken;
		kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		prog.delete();
		expAddr.delete();
		expVal.delete();
		// sum 10 down to 1
		prog.push_back(aluImm(3'b000, 1, 0, 12'd10));
		prog.push_back(aluImm(3'b000, 2, 0, 12'd0));
		prog.push_back(aluReg(7'h00, 3'b000, 2, 2, 1));
		prog.push_back(aluImm(3'b000, 1, 1, -12'sd1));
		prog.push_back(branch(3'b001, 1, 0, -13'sd8));
		prog.push_back(sw(2, 0, 12'h2f0));
		expectStore(32'h2f0, 32'd55);
		for (int k = 0; k < 12; k++) begin
			a = ((k % 2) == 0) ? 32'd3 : -32'sd4;
			b = (k < 4) ? a : -a - 1; // equal pairs for beq/bne, then mixed signs
			if (k == 1 || k == 3)
				b = a + 1;
			case (kinds[k / 2])
				3'b000:  taken = (a == b);
				3'b001:  taken = (a != b);
				3'b100:  taken = $signed(a) < $signed(b);
				3'b101:  taken = $signed(a) >= $signed(b);
				3'b110:  taken = a < b;
				default: taken = a >= b;
			endcase
			prog.push_back(aluImm(3'b000, 10, 0, 12'd0));
			prog.push_back(aluImm(3'b000, 5, 0, a[11:0]));
			prog.push_back(aluImm(3'b000, 6, 0, b[11:0]));
			prog.push_back(branch(kinds[k / 2], 5, 6, 13'd8));
			prog.push_back(aluImm(3'b000, 10, 0, 12'd1)); // runs only when not taken
			prog.push_back(sw(10, 0, 12'(32'h300 + 4 * k)));
			expectStore(32'h300 + 4 * k, taken ? 32'd0 : 32'd1);
		end
		// store in the squashed slot
		prog.push_back(branch(3'b000, 0, 0, 13'd8));
		prog.push_back(sw(0, 0, 12'h3f0));
		q = pcNow();
		prog.push_back(jal(20, 21'd8));
		prog.push_back(sw(0, 0, 12'h3f0));
		prog.push_back(sw(20, 0, 12'h340));
		expectStore(32'h340, q + 4);
		q = pcNow();
		prog.push_back({20'h00000, 5'd21, opAuipc});
		prog.push_back(aluImm(3'b000, 21, 21, 12'd16));
		prog.push_back(jalr(22, 21, 12'd0)); // lands on q+16
		prog.push_back(sw(0, 0, 12'h3f0));
		prog.push_back(sw(22, 0, 12'h344));
		expectStore(32'h344, q + 12);
		finishProgram();
		loadAndReset();
		runAndCheck("control flow", 0);
	endtask

	initial begin
		reset = 1'b1;
		clearMem = 1'b1;
		waitMode = 1'b0;
		testAluChain();
		testLoads();
		testControl();
		waitMode = 1'b1;
		testAluChain();
		testLoads();
		testControl();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- rv32iCore.f
common/rv32iPkg.sv
hw/core/pipeReg.sv
hw/core/regFile.sv
hw/core/instrDecode.sv
hw/core/execStage.sv
hw/core/hazardUnit.sv
hw/core/rv32iCore.sv
test/tbMem.sv
test/tbCore.sv

//--- Makefile
# Verilator build and run for the rv32iCore testbench

SRCS := $(shell cat rv32iCore.f)

obj_dir/VtbCore: rv32iCore.f $(SRCS)
	verilator --binary --timing --assert -f rv32iCore.f --top-module tbCore -Mdir obj_dir

run: obj_dir/VtbCore
	./obj_dir/VtbCore | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
